// ==== design/axi_rw_master.sv ====
`timescale 1ns/100ps

module axi_rw_master (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  start_i,
    input  mem_bus_pkg::mem_req_t req_i,
    output logic                  done_o,
    output mem_bus_pkg::mem_rsp_t rsp_o,

    output mem_bus_pkg::axi_req_t axi_o,
    input  mem_bus_pkg::axi_rsp_t axi_i
);

    mem_bus_pkg::rw_state_e wr_state_q;
    mem_bus_pkg::rw_state_e wr_state_d;
    mem_bus_pkg::rd_state_e rd_state_q;
    mem_bus_pkg::rd_state_e rd_state_d;

    mem_bus_pkg::mem_req_t req_q;
    mem_bus_pkg::mem_rsp_t rsp_q;
    mem_bus_pkg::addr_t    word_addr;
    mem_bus_pkg::xlen_t    rd_shifted;
    mem_bus_pkg::xlen_t    rd_data;

    logic       wr_done_q;
    logic [5:0] lane_shift;     // bit offset of the addressed byte
    logic       b_hs;
    logic       r_hs;

    // keep the low bytes for the given transfer size
    function automatic mem_bus_pkg::xlen_t size_mask(mem_bus_pkg::size_t size);
        mem_bus_pkg::xlen_t mask;
        case (size)
            3'd0:    mask = mem_bus_pkg::xlen_t'(8'hff);
            3'd1:    mask = mem_bus_pkg::xlen_t'(16'hffff);
            3'd2:    mask = mem_bus_pkg::xlen_t'(32'hffff_ffff);
            default: mask = '1;
        endcase
        return mask;
    endfunction

    // request is held only for the start cycle
    always_ff @(posedge clock) begin
        if (start_i) begin
            req_q <= req_i;
        end
    end

    assign lane_shift = {req_q.addr[2:0], 3'b000};
    assign word_addr  = {req_q.addr[mem_bus_pkg::ADDR_W-1:3], 3'b000};

    assign b_hs = (wr_state_q == mem_bus_pkg::wr_b) && axi_i.b_valid;
    assign r_hs = (rd_state_q == mem_bus_pkg::rd_r) && axi_i.r_valid;

    // write side
    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            mem_bus_pkg::wr_idle: begin
                if (start_i && req_i.we) begin
                    wr_state_d = mem_bus_pkg::wr_aw;
                end
            end
            mem_bus_pkg::wr_aw: begin
                if (axi_i.aw_ready) begin
                    wr_state_d = mem_bus_pkg::wr_w;
                end
            end
            mem_bus_pkg::wr_w: begin
                if (axi_i.w_ready) begin
                    wr_state_d = mem_bus_pkg::wr_b;
                end
            end
            mem_bus_pkg::wr_b: begin
                if (axi_i.b_valid) begin
                    wr_state_d = mem_bus_pkg::wr_idle;
                end
            end
            default: begin
                wr_state_d = mem_bus_pkg::wr_idle;
            end
        endcase
    end

    // read side
    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            mem_bus_pkg::rd_idle: begin
                if (start_i && !req_i.we) begin
                    rd_state_d = mem_bus_pkg::rd_ar;
                end
            end
            mem_bus_pkg::rd_ar: begin
                if (axi_i.ar_ready) begin
                    rd_state_d = mem_bus_pkg::rd_r;
                end
            end
            mem_bus_pkg::rd_r: begin
                if (axi_i.r_valid) begin
                    rd_state_d = mem_bus_pkg::rd_done;
                end
            end
            mem_bus_pkg::rd_done: begin
                rd_state_d = mem_bus_pkg::rd_idle;   // single done cycle
            end
            default: begin
                rd_state_d = mem_bus_pkg::rd_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= mem_bus_pkg::wr_idle;
            rd_state_q <= mem_bus_pkg::rd_idle;
            wr_done_q  <= 1'b0;
        end else begin
            wr_state_q <= wr_state_d;
            rd_state_q <= rd_state_d;
            wr_done_q  <= b_hs;
        end
    end

    // read lane extraction
    assign rd_shifted = axi_i.r_data >> lane_shift;
    assign rd_data    = rd_shifted & size_mask(req_q.size);

    always_ff @(posedge clock) begin
        if (b_hs) begin
            rsp_q.rdata <= '0;
            rsp_q.err   <= (axi_i.b_resp != mem_bus_pkg::AXI_RESP_OKAY);
        end else if (r_hs) begin
            rsp_q.rdata <= rd_data;
            rsp_q.err   <= (axi_i.r_resp != mem_bus_pkg::AXI_RESP_OKAY);
        end
    end

    assign done_o = wr_done_q || (rd_state_q == mem_bus_pkg::rd_done);
    assign rsp_o  = rsp_q;

    // write channels, data and strobes moved into their lanes
    assign axi_o.aw_valid = (wr_state_q == mem_bus_pkg::wr_aw);
    assign axi_o.aw_addr  = word_addr;
    assign axi_o.aw_size  = req_q.size;
    assign axi_o.w_valid  = (wr_state_q == mem_bus_pkg::wr_w);
    assign axi_o.w_data   = req_q.wdata << lane_shift;
    assign axi_o.w_strb   = req_q.wmask << req_q.addr[2:0];
    assign axi_o.w_last   = axi_o.w_valid;     // always one beat
    assign axi_o.b_ready  = (wr_state_q == mem_bus_pkg::wr_b);

    // read channels
    assign axi_o.ar_valid = (rd_state_q == mem_bus_pkg::rd_ar);
    assign axi_o.ar_addr  = word_addr;
    assign axi_o.ar_size  = req_q.size;
    assign axi_o.r_ready  = (rd_state_q == mem_bus_pkg::rd_r);

endmodule

// ==== design/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int XLEN   = 64;
    localparam int STRB_W = XLEN / 8;
    localparam int ADDR_W = 32;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;  // 0 byte .. 3 doubleword
    typedef logic [1:0]        resp_t;

    // one port request, data and mask right-aligned
    typedef struct packed {
        addr_t addr;
        logic  we;
        size_t size;
        xlen_t wdata;
        strb_t wmask;
    } mem_req_t;

    typedef struct packed {
        xlen_t rdata;       // zero-extended
        logic  err;
    } mem_rsp_t;

    // master side of the bus
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        size_t aw_size;
        logic  w_valid;
        xlen_t w_data;
        strb_t w_strb;
        logic  w_last;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        size_t ar_size;
        logic  r_ready;
    } axi_req_t;

    // slave side of the bus
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        xlen_t r_data;
        resp_t r_resp;
    } axi_rsp_t;

    typedef enum logic [1:0] {wr_idle, wr_aw, wr_w, wr_b} rw_state_e;
    typedef enum logic [1:0] {rd_idle, rd_ar, rd_r, rd_done} rd_state_e;
    typedef enum logic {arb_idle, arb_busy} arb_state_e;

endpackage

// ==== design/mem_bus_top.sv ====
`timescale 1ns/100ps

module mem_bus_top (
    input  logic                  clock,
    input  logic                  reset,

    // instruction fetch port
    input  logic                  if_req_i,
    input  mem_bus_pkg::mem_req_t if_req_data_i,
    output logic                  if_done_o,
    output mem_bus_pkg::mem_rsp_t if_rsp_o,

    // load/store port
    input  logic                  ls_req_i,
    input  mem_bus_pkg::mem_req_t ls_req_data_i,
    output logic                  ls_done_o,
    output mem_bus_pkg::mem_rsp_t ls_rsp_o,

    // external bus
    output mem_bus_pkg::axi_req_t axi_o,
    input  mem_bus_pkg::axi_rsp_t axi_i
);

    logic                  start;
    logic                  done;
    mem_bus_pkg::mem_req_t req;
    mem_bus_pkg::mem_rsp_t rsp;

    mem_port_arbiter u_arbiter (
        .clock         (clock),
        .reset         (reset),
        .if_req_i      (if_req_i),
        .if_req_data_i (if_req_data_i),
        .if_done_o     (if_done_o),
        .if_rsp_o      (if_rsp_o),
        .ls_req_i      (ls_req_i),
        .ls_req_data_i (ls_req_data_i),
        .ls_done_o     (ls_done_o),
        .ls_rsp_o      (ls_rsp_o),
        .start_o       (start),
        .req_o         (req),
        .done_i        (done),
        .rsp_i         (rsp)
    );

    axi_rw_master u_bridge (
        .clock   (clock),
        .reset   (reset),
        .start_i (start),
        .req_i   (req),
        .done_o  (done),
        .rsp_o   (rsp),
        .axi_o   (axi_o),
        .axi_i   (axi_i)
    );

endmodule

// ==== design/mem_port_arbiter.sv ====
`timescale 1ns/100ps

module mem_port_arbiter (
    input  logic                  clock,
    input  logic                  reset,

    // instruction fetch port
    input  logic                  if_req_i,
    input  mem_bus_pkg::mem_req_t if_req_data_i,
    output logic                  if_done_o,
    output mem_bus_pkg::mem_rsp_t if_rsp_o,

    // load/store port
    input  logic                  ls_req_i,
    input  mem_bus_pkg::mem_req_t ls_req_data_i,
    output logic                  ls_done_o,
    output mem_bus_pkg::mem_rsp_t ls_rsp_o,

    // bridge side
    output logic                  start_o,
    output mem_bus_pkg::mem_req_t req_o,
    input  logic                  done_i,
    input  mem_bus_pkg::mem_rsp_t rsp_i
);

    mem_bus_pkg::arb_state_e state_q;
    mem_bus_pkg::arb_state_e state_d;

    logic grant_q;      // 0 fetch, 1 load/store
    logic last_q;       // port served last
    logic pick;
    logic sel;
    logic any_req;

    assign any_req = if_req_i | ls_req_i;

    // on a tie the port not served last goes first
    always_comb begin
        if (if_req_i && ls_req_i) begin
            pick = ~last_q;
        end else begin
            pick = ls_req_i;
        end
    end

    assign start_o = (state_q == mem_bus_pkg::arb_idle) && any_req;
    assign sel     = (state_q == mem_bus_pkg::arb_idle) ? pick : grant_q;
    assign req_o   = sel ? ls_req_data_i : if_req_data_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_bus_pkg::arb_idle: begin
                if (any_req) begin
                    state_d = mem_bus_pkg::arb_busy;
                end
            end
            mem_bus_pkg::arb_busy: begin
                if (done_i) begin
                    state_d = mem_bus_pkg::arb_idle;
                end
            end
            default: begin
                state_d = mem_bus_pkg::arb_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= mem_bus_pkg::arb_idle;
            grant_q <= 1'b0;
            last_q  <= 1'b1;        // fetch wins the first tie
        end else begin
            state_q <= state_d;
            if (start_o) begin
                grant_q <= pick;
                last_q  <= pick;
            end
        end
    end

    // only the granted port sees the done pulse
    assign if_done_o = (state_q == mem_bus_pkg::arb_busy) && done_i && !grant_q;
    assign ls_done_o = (state_q == mem_bus_pkg::arb_busy) && done_i && grant_q;

    assign if_rsp_o = rsp_i;
    assign ls_rsp_o = rsp_i;

endmodule

// ==== filelist.f ====
design/mem_bus_pkg.sv
design/mem_port_arbiter.sv
design/axi_rw_master.sv
design/mem_bus_top.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_model.sv
testbench/tb_mem_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory bus testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_mem_bus -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model (
    input  logic                  clock,
    input  logic                  reset,
    input  mem_bus_pkg::axi_req_t axi_i,
    output mem_bus_pkg::axi_rsp_t axi_o
);

    logic [7:0] mem [0:4095];
    integer     seed;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] ar_wait;
    logic [1:0] b_wait;
    logic [1:0] r_wait;
    logic       b_pend;
    logic       r_pend;
    mem_bus_pkg::addr_t wr_addr;
    mem_bus_pkg::addr_t rd_addr;

    // fill byte from the whole 12-bit address
    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    initial begin
        seed = 32'hd9d0;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = fill_byte(a[11:0]);
        end
    end

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            axi_o   <= '0;
            aw_wait <= '0;
            w_wait  <= '0;
            ar_wait <= '0;
            b_wait  <= '0;
            r_wait  <= '0;
            b_pend  <= 1'b0;
            r_pend  <= 1'b0;
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (axi_i.aw_valid && !axi_o.aw_ready) begin
                if (aw_wait == 2'd0) axi_o.aw_ready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end else begin
                axi_o.aw_ready <= 1'b0;
                aw_wait        <= 2'($random(seed));
            end
            if (axi_i.aw_valid && axi_o.aw_ready) wr_addr <= axi_i.aw_addr;

            if (axi_i.w_valid && !axi_o.w_ready) begin
                if (w_wait == 2'd0) axi_o.w_ready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end else begin
                axi_o.w_ready <= 1'b0;
                w_wait        <= 2'($random(seed));
            end
            if (axi_i.w_valid && axi_o.w_ready) begin
                if (wr_addr < 32'h1000) begin
                    for (int i = 0; i < 8; i++) begin
                        if (axi_i.w_strb[i]) mem[wr_addr[11:0] + 12'(i)] <= axi_i.w_data[8*i +: 8];
                    end
                end
                axi_o.b_resp <= (wr_addr < 32'h1000) ? 2'b00 : 2'b10;   // SLVERR above 4 KiB
                b_pend       <= 1'b1;
                b_wait       <= 2'($random(seed));
            end

            if (b_pend && !axi_o.b_valid) begin
                if (b_wait == 2'd0) axi_o.b_valid <= 1'b1;
                else b_wait <= b_wait - 2'd1;
            end
            if (axi_o.b_valid && axi_i.b_ready) begin
                axi_o.b_valid <= 1'b0;
                b_pend        <= 1'b0;
            end

            if (axi_i.ar_valid && !axi_o.ar_ready) begin
                if (ar_wait == 2'd0) axi_o.ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end else begin
                axi_o.ar_ready <= 1'b0;
                ar_wait        <= 2'($random(seed));
            end
            if (axi_i.ar_valid && axi_o.ar_ready) begin
                rd_addr <= axi_i.ar_addr;
                r_pend  <= 1'b1;
                r_wait  <= 2'($random(seed));
            end

            if (r_pend && !axi_o.r_valid) begin
                if (r_wait == 2'd0) begin
                    axi_o.r_valid <= 1'b1;
                    axi_o.r_resp  <= (rd_addr < 32'h1000) ? 2'b00 : 2'b10;
                    for (int i = 0; i < 8; i++) begin
                        axi_o.r_data[8*i +: 8] <= (rd_addr < 32'h1000) ?
                                                  mem[rd_addr[11:0] + 12'(i)] : 8'h00;
                    end
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            if (axi_o.r_valid && axi_i.r_ready) begin
                axi_o.r_valid <= 1'b0;
                r_pend        <= 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;     // 20 ns period
    end

    initial begin
        reset_o = 1'b0;
        repeat (8) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b1;
    end

endmodule

// ==== testbench/tb_mem_bus.sv ====
`timescale 1ns/100ps

module tb_mem_bus;

    localparam int N_XFERS = 220;                 // 40 + 120 + 48 + 12
    localparam int TIMEOUT = N_XFERS * 20 + 200;

    logic clock;
    logic reset;
    logic if_req;
    logic ls_req;
    logic if_done;
    logic ls_done;
    mem_bus_pkg::mem_req_t if_req_data;
    mem_bus_pkg::mem_req_t ls_req_data;
    mem_bus_pkg::mem_rsp_t if_rsp;
    mem_bus_pkg::mem_rsp_t ls_rsp;
    mem_bus_pkg::axi_req_t axi_req;
    mem_bus_pkg::axi_rsp_t axi_rsp;
    mem_bus_pkg::mem_req_t r_if;
    mem_bus_pkg::mem_req_t r_ls;

    logic [7:0] ref_mem [0:4095];
    integer seed;
    int     checks, errors, errs_before, cycles;
    int     req_count, done_count, pend_if, pend_ls;
    logic   alt_mode, prev_port, prev_valid;
    logic   aw_hold, w_hold, ar_hold;
    mem_bus_pkg::axi_req_t axi_q;
    mem_bus_pkg::addr_t    ax_addr;
    mem_bus_pkg::size_t    ax_size;
    mem_bus_pkg::strb_t    w_strb_hs;
    logic                  w_last_hs;

    tb_clock_gen u_clk (.clock_o(clock), .reset_o(reset));

    mem_bus_top DUT (
        .clock(clock), .reset(reset),
        .if_req_i(if_req), .if_req_data_i(if_req_data), .if_done_o(if_done), .if_rsp_o(if_rsp),
        .ls_req_i(ls_req), .ls_req_data_i(ls_req_data), .ls_done_o(ls_done), .ls_rsp_o(ls_rsp),
        .axi_o(axi_req), .axi_i(axi_rsp)
    );

    axi_mem_model u_mem (.clock(clock), .reset(reset), .axi_i(axi_req), .axi_o(axi_rsp));

    task automatic check_val(input string name, input mem_bus_pkg::xlen_t exp,
                             input mem_bus_pkg::xlen_t got);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_fail(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic rand_req(input logic we, input mem_bus_pkg::size_t size,
                            output mem_bus_pkg::mem_req_t r);
        r.addr  = mem_bus_pkg::addr_t'($random(seed)) & 32'hfff & ~((32'd1 << size) - 32'd1);
        r.we    = we;
        r.size  = size;
        r.wdata = {$random(seed), $random(seed)};
        r.wmask = mem_bus_pkg::strb_t'((1 << (1 << size)) - 1);
    endtask

    // one transfer on a port, leaves req high for a back-to-back follow-up
    task automatic xfer(input logic port, input mem_bus_pkg::mem_req_t r);
        mem_bus_pkg::mem_rsp_t rsp;
        mem_bus_pkg::xlen_t    exp;
        mem_bus_pkg::strb_t    exp_strb;
        logic  exp_err;
        int    nb;
        string pn;
        nb      = 1 << r.size;
        exp_err = (r.addr >= 32'h1000);
        pn      = port ? "ls_rsp" : "if_rsp";
        exp     = '0;
        for (int i = 0; i < nb; i++) exp[8*i +: 8] = ref_mem[r.addr[11:0] + 12'(i)];
        if (port) begin
            ls_req_data = r;
            ls_req      = 1'b1;
            pend_ls++;
        end else begin
            if_req_data = r;
            if_req      = 1'b1;
            pend_if++;
        end
        req_count++;
        do @(negedge clock); while (!(port ? ls_done : if_done));
        rsp = port ? ls_rsp : if_rsp;
        check_val({pn, ".err"}, mem_bus_pkg::xlen_t'(exp_err), mem_bus_pkg::xlen_t'(rsp.err));
        if (!r.we && !exp_err) check_val({pn, ".rdata"}, exp, rsp.rdata);
        check_val(r.we ? "axi_o.aw_addr" : "axi_o.ar_addr",
                  mem_bus_pkg::xlen_t'(r.addr & ~32'h7), mem_bus_pkg::xlen_t'(ax_addr));
        check_val(r.we ? "axi_o.aw_size" : "axi_o.ar_size",
                  mem_bus_pkg::xlen_t'(r.size), mem_bus_pkg::xlen_t'(ax_size));
        if (r.we) begin
            exp_strb = '0;
            for (int i = 0; i < nb; i++) exp_strb[r.addr[2:0] + i] = 1'b1;   // addressed lanes
            check_val("axi_o.w_strb", mem_bus_pkg::xlen_t'(exp_strb),
                      mem_bus_pkg::xlen_t'(w_strb_hs));
            check_val("axi_o.w_last", 64'd1, mem_bus_pkg::xlen_t'(w_last_hs));
        end
        if (r.we && !exp_err) begin
            for (int i = 0; i < nb; i++) begin
                if (r.wmask[i]) ref_mem[r.addr[11:0] + 12'(i)] = r.wdata[8*i +: 8];
            end
        end
    endtask

    task automatic release_port(input logic port);
        if (port) ls_req = 1'b0;
        else if_req = 1'b0;
    endtask

    task automatic test_done(input string name);
        $display("test %s finished with %0d errors", name, errors - errs_before);
        errs_before = errors;
    endtask

    // done bookkeeping, sampled before the edge updates
    always @(posedge clock) begin
        if (if_done || ls_done) begin
            done_count++;
            assert (!(if_done && ls_done))
                else report_fail("done pulses on both ports at once");
            assert (!if_done || pend_if > 0)
                else report_fail("fetch port done without a request");
            assert (!ls_done || pend_ls > 0)
                else report_fail("load/store port done without a request");
            if (if_done) pend_if--;
            if (ls_done) pend_ls--;
            assert (!(alt_mode && prev_valid && prev_port == ls_done))
                else report_fail("done pulses did not alternate between ports");
            prev_port  = ls_done;
            prev_valid = 1'b1;
        end
    end

    // valid must hold with stable fields until ready
    always @(posedge clock) begin
        assert (!aw_hold || (axi_req.aw_valid && axi_req.aw_addr == axi_q.aw_addr
                             && axi_req.aw_size == axi_q.aw_size))
            else report_fail("aw_valid dropped or aw fields changed before aw_ready");
        assert (!w_hold || (axi_req.w_valid && axi_req.w_data == axi_q.w_data
                            && axi_req.w_strb == axi_q.w_strb
                            && axi_req.w_last == axi_q.w_last))
            else report_fail("w_valid dropped or w fields changed before w_ready");
        assert (!ar_hold || (axi_req.ar_valid && axi_req.ar_addr == axi_q.ar_addr
                             && axi_req.ar_size == axi_q.ar_size))
            else report_fail("ar_valid dropped or ar fields changed before ar_ready");
        aw_hold = axi_req.aw_valid && !axi_rsp.aw_ready;
        w_hold  = axi_req.w_valid && !axi_rsp.w_ready;
        ar_hold = axi_req.ar_valid && !axi_rsp.ar_ready;
        axi_q   = axi_req;
        // fields of the latest handshakes, looked at when done comes
        if (axi_req.aw_valid && axi_rsp.aw_ready) begin
            ax_addr = axi_req.aw_addr;
            ax_size = axi_req.aw_size;
        end
        if (axi_req.ar_valid && axi_rsp.ar_ready) begin
            ax_addr = axi_req.ar_addr;
            ax_size = axi_req.ar_size;
        end
        if (axi_req.w_valid && axi_rsp.w_ready) begin
            w_strb_hs = axi_req.w_strb;
            w_last_hs = axi_req.w_last;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("run hung: transfers still open after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        seed = 32'hd9d0;
        {checks, errors, errs_before, cycles} = '0;
        {req_count, done_count, pend_if, pend_ls} = '0;
        {alt_mode, prev_port, prev_valid, aw_hold, w_hold, ar_hold} = '0;
        if_req      = 1'b0;
        ls_req      = 1'b0;
        if_req_data = '0;
        ls_req_data = '0;
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;   // same fill as the memory
        end

        @(posedge reset);
        repeat (4) begin
            @(negedge clock);
            check_val("axi valids/readies and done outputs", '0,
                      {axi_req.aw_valid, axi_req.w_valid, axi_req.b_ready, axi_req.ar_valid,
                       axi_req.r_ready, if_done, ls_done});
        end
        test_done("1 reset state");

        repeat (40) begin
            rand_req(1'b0, 3'd3, r_if);
            xfer(1'b0, r_if);
        end
        release_port(1'b0);
        test_done("2 fetch doubleword reads");

        repeat (40) begin
            rand_req(1'b1, mem_bus_pkg::size_t'($random(seed) & 3), r_ls);
            xfer(1'b1, r_ls);
            r_ls.we = 1'b0;
            xfer(1'b1, r_ls);
            r_ls.size = 3'd3;
            r_ls.addr = r_ls.addr & ~32'h7;      // whole word, neighbours untouched
            xfer(1'b1, r_ls);
        end
        release_port(1'b1);
        test_done("3 load/store writes and read-back");

        @(negedge clock);
        alt_mode   = 1'b1;
        prev_valid = 1'b0;
        fork
            begin
                repeat (24) begin
                    rand_req(1'b0, 3'd3, r_if);
                    xfer(1'b0, r_if);
                end
                release_port(1'b0);
            end
            begin
                repeat (24) begin
                    rand_req(1'b0, mem_bus_pkg::size_t'($random(seed) & 3), r_ls);
                    xfer(1'b1, r_ls);
                end
                release_port(1'b1);
            end
        join
        @(negedge clock);
        alt_mode = 1'b0;
        test_done("4 both ports busy");

        repeat (4) begin
            rand_req(1'b1, 3'd3, r_ls);
            r_ls.addr = r_ls.addr | 32'h1000;
            xfer(1'b1, r_ls);
            release_port(1'b1);
            r_if    = r_ls;
            r_if.we = 1'b0;
            xfer(1'b0, r_if);
            release_port(1'b0);
            r_ls.we   = 1'b0;
            r_ls.addr = r_ls.addr & 32'hfff;     // aliased low word stays untouched
            xfer(1'b1, r_ls);
            release_port(1'b1);
        end
        test_done("5 out-of-range accesses");

        repeat (2) @(negedge clock);
        check_val("done count", mem_bus_pkg::xlen_t'(req_count), mem_bus_pkg::xlen_t'(done_count));
        test_done("6 protocol and transfer count");

        $display("checks %0d, errors %0d, transfers %0d", checks, errors, req_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
